/* loongmem.f */
+incdir+bench
logic/mem_pkg.sv
logic/mem_stage.sv
logic/fetch_unit.sv
logic/mem_arbiter.sv
logic/unified_sram.sv
logic/mem_subsystem.sv
bench/tb_mem_subsystem.sv

/* bench/mem_ref_model.svh */
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

data_t ref_mem [MEM_WORDS];     // Mirror of the SRAM contents
addr_t model_pc;                // Next pc the fetch stream should return

function automatic int word_of(addr_t a);
    return int'((a >> 2) % MEM_WORDS);
endfunction

// Bytes touched by one access, 0 for no memory access
function automatic int access_size(lsu_op_t op);
    case (op)
        LD_B, LD_BU, ST_B: return 1;
        LD_H, LD_HU, ST_H: return 2;
        LD_W, ST_W:        return 4;
        default:           return 0;
    endcase
endfunction

function automatic logic is_store(lsu_op_t op);
    return op inside {ST_B, ST_H, ST_W};
endfunction

function automatic logic is_misaligned(lsu_op_t op, addr_t a);
    int size;
    size = access_size(op);
    return (size > 1) && (a % size != 0);
endfunction

function automatic void apply_store(lsu_op_t op, addr_t a, data_t d);
    int w;
    int lane;
    w = word_of(a);
    for (int i = 0; i < access_size(op); i++) begin
        lane = a[1:0] + i;
        ref_mem[w][lane*8 +: 8] = d[i*8 +: 8];
    end
endfunction

function automatic data_t expected_load(lsu_op_t op, addr_t a);
    data_t v;
    int    w;
    v = '0;
    w = word_of(a);
    for (int i = 0; i < access_size(op); i++)
        v[i*8 +: 8] = ref_mem[w][(a[1:0] + i)*8 +: 8];
    // Sign fill from the top bit of the loaded value
    if (op == LD_B && v[7])
        v[31:8] = '1;
    if (op == LD_H && v[15])
        v[31:16] = '1;
    return v;
endfunction

function automatic data_t expected_rw_data(lsu_op_t op, addr_t a);
    if (access_size(op) == 0)
        return a;       // ALU result passes through
    return expected_load(op, a);
endfunction

function automatic void clear_model();
    for (int i = 0; i < MEM_WORDS; i++)
        ref_mem[i] = '0;
    model_pc = '0;
endfunction

`endif

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_OPS      = 800;
    localparam int STORE_OPS  = 100;
    localparam int LOAD_OPS   = 200;
    localparam int MIXED_FROM = STORE_OPS + LOAD_OPS;

    typedef struct packed {
        wb_pkt_t  wb;
        csr_pkt_t csr;
        logic     ale;
        logic     check_rw_data;
    } exp_item_t;

    logic     clk;
    logic     rst_n;
    logic     ex_valid;
    ex_pkt_t  ex_pkt;
    csr_pkt_t ex_csr;
    logic     wb_valid;
    wb_pkt_t  wb_pkt;
    csr_pkt_t wb_csr;
    logic     ale;
    logic     redirect;
    addr_t    redirect_pc;
    logic     fetch_valid;
    addr_t    fetch_pc;
    inst_t    fetch_inst;

    integer    seed = 32'hf5b91e1e;
    exp_item_t exp_q [$];
    logic      prev_valid = 1'b0;
    int        fetch_count = 0;

    lsu_op_t store_ops [3]  = '{ST_B, ST_H, ST_W};
    lsu_op_t load_ops  [5]  = '{LD_B, LD_H, LD_W, LD_BU, LD_HU};
    lsu_op_t any_ops   [10] = '{LD_B, LD_H, LD_W, ST_B, ST_H, ST_W,
                                LD_BU, LD_HU, LSU_NONE, lsu_op_t'(4'b0011)};

    `include "mem_ref_model.svh"

    mem_subsystem u_mem_subsystem (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_valid    (ex_valid),
        .ex_pkt      (ex_pkt),
        .ex_csr      (ex_csr),
        .wb_valid    (wb_valid),
        .wb_pkt      (wb_pkt),
        .wb_csr      (wb_csr),
        .ale         (ale),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    initial begin
        #(N_OPS * 4 * CLK_PERIOD);
        $display("Error: run timed out waiting for results");
        stop_run("watchdog expired");
    end

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            stop_run("data mismatch");
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            stop_run("instruction mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            stop_run("flag mismatch");
        end
    endtask

    function automatic logic [1:0] pick_offset(lsu_op_t op, logic [1:0] r);
        case (access_size(op))
            2:       return {r[1], 1'b0};
            4:       return 2'b00;
            default: return r;
        endcase
    endfunction

    // r bits: 0 rw_en, 1 csr en, 2 sign bits, 4:3 offset, 9:5 word, 12:10 idle,
    // 17:13 redirect, 19:18 misalign, 31:20 op
    task automatic drive_op(input int i);
        ex_pkt_t     p;
        csr_pkt_t    c;
        logic [31:0] r;
        logic [31:0] r2;
        logic [1:0]  off;
        r  = $random(seed);
        r2 = $random(seed);
        p.pc         = $random(seed);
        p.inst       = $random(seed);
        p.rw_en      = r[0];
        p.rw_addr    = r2[28:24];
        p.lsu_data   = $random(seed);
        c.rw_en      = r[1];
        c.rw_addr    = r2[13:0];
        c.rw_data    = $random(seed);
        if (r[2])
            p.lsu_data = p.lsu_data | 32'h80808080;
        if (i < STORE_OPS)
            p.lsu_op = store_ops[r[31:20] % 3];
        else if (i < MIXED_FROM)
            p.lsu_op = load_ops[r[31:20] % 5];
        else
            p.lsu_op = any_ops[r[31:20] % 10];
        off = pick_offset(p.lsu_op, r[4:3]);
        if (i >= MIXED_FROM && r[19:18] == 2'b00)
            off = r[4:3];
        if (access_size(p.lsu_op) == 0)
            p.ex_result = $random(seed);
        else
            p.ex_result = {25'b0, r[9:5], off};     // Small window so loads hit stores
        ex_valid <= (i < MIXED_FROM) || (r[12:10] > 3'd2);
        ex_pkt   <= p;
        ex_csr   <= c;
        if (i >= MIXED_FROM && r[17:13] == 5'd0) begin
            redirect    <= 1'b1;
            redirect_pc <= {25'b0, r2[20:16], 2'b00};
        end else begin
            redirect <= 1'b0;
        end
    endtask

    task automatic record_input();
        exp_item_t e;
        logic      bad;
        bad = is_misaligned(ex_pkt.lsu_op, ex_pkt.ex_result);
        e.wb.pc          = ex_pkt.pc;
        e.wb.inst        = ex_pkt.inst;
        e.wb.rw_en       = ex_pkt.rw_en & ~bad;
        e.wb.rw_addr     = ex_pkt.rw_addr;
        e.wb.rw_data     = expected_rw_data(ex_pkt.lsu_op, ex_pkt.ex_result);
        e.csr            = ex_csr;
        e.ale            = bad;
        e.check_rw_data  = !bad && !is_store(ex_pkt.lsu_op);
        exp_q.push_back(e);
        if (!bad && is_store(ex_pkt.lsu_op))
            apply_store(ex_pkt.lsu_op, ex_pkt.ex_result, ex_pkt.lsu_data);
    endtask

    task automatic compare_wb();
        exp_item_t e;
        if (exp_q.size() == 0) begin
            $display("Error: write-back result arrived with nothing expected");
            stop_run("unexpected write-back");
        end
        e = exp_q.pop_front();
        check_data("wb pc", e.wb.pc, wb_pkt.pc);
        check_inst("wb inst", e.wb.inst, wb_pkt.inst);
        check_flag("wb rw_en", e.wb.rw_en, wb_pkt.rw_en);
        check_data("wb rw_addr", data_t'(e.wb.rw_addr), data_t'(wb_pkt.rw_addr));
        if (e.check_rw_data)
            check_data("wb rw_data", e.wb.rw_data, wb_pkt.rw_data);
        check_flag("csr rw_en", e.csr.rw_en, wb_csr.rw_en);
        check_data("csr rw_addr", data_t'(e.csr.rw_addr), data_t'(wb_csr.rw_addr));
        check_data("csr rw_data", e.csr.rw_data, wb_csr.rw_data);
        check_flag("ale", e.ale, ale);
    endtask

    task automatic compare_fetch();
        check_data("fetch_pc", model_pc, fetch_pc);
        check_inst("fetch_inst", ref_mem[word_of(model_pc)], fetch_inst);
        model_pc    = model_pc + 32'd4;
        fetch_count = fetch_count + 1;
    endtask

    // Sampled mid-cycle; fetch read sees memory before this cycle's store
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag("wb_valid delay", prev_valid, wb_valid);
            if (wb_valid)
                compare_wb();
            else
                check_flag("ale idle", 1'b0, ale);
            if (fetch_valid)
                compare_fetch();
            if (redirect)
                model_pc = redirect_pc;
            if (ex_valid)
                record_input();
            prev_valid = ex_valid;
        end
    end

    initial begin
        rst_n       = 1'b0;
        ex_valid    = 1'b0;
        ex_pkt      = '0;
        ex_csr      = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        clear_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("reset wb_valid", 1'b0, wb_valid);
        check_flag("reset ale", 1'b0, ale);
        check_flag("reset fetch_valid", 1'b0, fetch_valid);
        @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_OPS; i++) begin
            @(posedge clk);
            drive_op(i);
        end
        @(posedge clk);
        ex_valid <= 1'b0;
        redirect <= 1'b0;
        repeat (20) @(posedge clk);
        while (exp_q.size() != 0)
            @(posedge clk);
        check_flag("fetch progress", 1'b1, fetch_count > 0);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  mem_pkg::ex_pkt_t  ex_pkt,
    input  mem_pkg::csr_pkt_t ex_csr,
    output logic              wb_valid,
    output mem_pkg::wb_pkt_t  wb_pkt,
    output mem_pkg::csr_pkt_t wb_csr,
    output logic              ale,
    input  logic              redirect,
    input  mem_pkg::addr_t    redirect_pc,
    output logic              fetch_valid,
    output mem_pkg::addr_t    fetch_pc,
    output mem_pkg::inst_t    fetch_inst
);
    import mem_pkg::*;

    mem_req_t data_req;
    mem_req_t fetch_req;
    mem_req_t sram_req;
    logic     fetch_gnt;
    data_t    rdata;        // Seen by both requesters

    mem_stage u_mem_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex_pkt   (ex_pkt),
        .ex_csr   (ex_csr),
        .data_req (data_req),
        .rdata    (rdata),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt),
        .wb_csr   (wb_csr),
        .ale      (ale)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_gnt   (fetch_gnt),
        .rdata       (rdata),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_req  (data_req),
        .fetch_req (fetch_req),
        .fetch_gnt (fetch_gnt),
        .sram_req  (sram_req)
    );

    unified_sram u_unified_sram (
        .clk      (clk),
        .sram_req (sram_req),
        .rdata    (rdata)
    );

endmodule

/* logic/unified_sram.sv */
`timescale 1ns/1ps

module unified_sram (
    input  logic              clk,
    input  mem_pkg::mem_req_t sram_req,
    output mem_pkg::data_t    rdata
);
    import mem_pkg::*;

    data_t mem [MEM_WORDS];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (sram_req.en && sram_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (sram_req.strb[b])
                    mem[sram_req.idx][b*8 +: 8] <= sram_req.wdata[b*8 +: 8];
            end
        end
    end

    // Read-first, one cycle latency
    always_ff @(posedge clk) begin
        if (sram_req.en)
            rdata <= mem[sram_req.idx];
    end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t data_req,
    input  mem_pkg::mem_req_t fetch_req,
    output logic              fetch_gnt,
    output mem_pkg::mem_req_t sram_req
);
    import mem_pkg::*;

    logic data_sel;
    logic fetch_owns_q;     // Read in flight belongs to fetch

    // Data port always wins
    assign data_sel  = data_req.en;
    assign fetch_gnt = ~data_sel & fetch_req.en;

    always_comb begin
        if (data_sel) begin
            sram_req = data_req;
        end else begin
            sram_req = fetch_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            fetch_owns_q <= 1'b0;
        else
            fetch_owns_q <= fetch_gnt;
    end

    // A fetch slot was a plain read on the SRAM port
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_owns_q |-> $past(sram_req.en && !sram_req.we));

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              redirect,
    input  mem_pkg::addr_t    redirect_pc,
    output mem_pkg::mem_req_t fetch_req,
    input  logic              fetch_gnt,
    input  mem_pkg::data_t    rdata,
    output logic              fetch_valid,
    output mem_pkg::addr_t    fetch_pc,
    output mem_pkg::inst_t    fetch_inst
);
    import mem_pkg::*;

    addr_t pc_q;
    addr_t pc_out_q;    // pc of the read in flight
    logic  pending_q;

    // Request stays up until granted
    always_comb begin
        fetch_req.en    = 1'b1;
        fetch_req.we    = 1'b0;
        fetch_req.idx   = pc_q[MEM_AWIDTH+1:2];
        fetch_req.wdata = '0;
        fetch_req.strb  = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q      <= '0;
            pending_q <= 1'b0;
        end else begin
            pending_q <= fetch_gnt & ~redirect;     // Redirect drops this read
            if (redirect)
                pc_q <= redirect_pc;
            else if (fetch_gnt)
                pc_q <= pc_q + 32'd4;
        end
    end

    // Step taken at grant so back-to-back reads stay in order
    always_ff @(posedge clk) begin
        if (fetch_gnt)
            pc_out_q <= pc_q;
    end

    assign fetch_valid = pending_q;
    assign fetch_pc    = pc_out_q;
    assign fetch_inst  = rdata;

    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |-> $past(fetch_gnt));

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  mem_pkg::ex_pkt_t  ex_pkt,
    input  mem_pkg::csr_pkt_t ex_csr,
    output mem_pkg::mem_req_t data_req,
    input  mem_pkg::data_t    rdata,
    output logic              wb_valid,
    output mem_pkg::wb_pkt_t  wb_pkt,
    output mem_pkg::csr_pkt_t wb_csr,
    output logic              ale
);
    import mem_pkg::*;

    logic      is_load;
    logic      is_store;
    logic [1:0] size;       // 0 byte, 1 half, 2 word
    logic [1:0] off;
    logic      misaligned;
    strb_t     st_strb;

    ex_pkt_t   pkt_d;
    ex_pkt_t   pkt_q;
    csr_pkt_t  csr_q;
    logic      wb_valid_q;
    logic      ale_q;

    data_t     ld_shift;
    data_t     rw_data;

    assign off = ex_pkt.ex_result[1:0];

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = 2'd0;
        case (ex_pkt.lsu_op)
            LD_B, LD_BU: begin
                is_load = 1'b1;
            end
            LD_H, LD_HU: begin
                is_load = 1'b1;
                size    = 2'd1;
            end
            LD_W: begin
                is_load = 1'b1;
                size    = 2'd2;
            end
            ST_B: is_store = 1'b1;
            ST_H: begin
                is_store = 1'b1;
                size     = 2'd1;
            end
            ST_W: begin
                is_store = 1'b1;
                size     = 2'd2;
            end
            default: ;      // Unknown codes act as no access
        endcase
    end

    // Halfword at offset 1 or 3 and word at any nonzero offset
    assign misaligned = (is_load | is_store) &
                        (((size == 2'd1) & off[0]) | ((size == 2'd2) & (off != 2'd0)));

    always_comb begin
        case (size)
            2'd0:    st_strb = 4'b0001 << off;
            2'd1:    st_strb = 4'b0011 << off;
            default: st_strb = 4'b1111;
        endcase
    end

    always_comb begin
        data_req.en    = ex_valid & (is_load | is_store) & ~misaligned;
        data_req.we    = is_store;
        data_req.idx   = ex_pkt.ex_result[MEM_AWIDTH+1:2];
        data_req.wdata = ex_pkt.lsu_data << {off, 3'b000};    // Move to byte lane
        data_req.strb  = is_store ? st_strb : 4'b0000;
    end

    always_comb begin
        pkt_d        = ex_pkt;
        pkt_d.rw_en  = ex_pkt.rw_en & ~misaligned;
        pkt_d.lsu_op = misaligned ? LSU_NONE : ex_pkt.lsu_op;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
            ale_q      <= 1'b0;
        end else begin
            wb_valid_q <= ex_valid;
            ale_q      <= ex_valid & misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            pkt_q <= pkt_d;
            csr_q <= ex_csr;
        end
    end

    // Load data arrives one cycle after the request
    assign ld_shift = rdata >> {pkt_q.ex_result[1:0], 3'b000};

    always_comb begin
        case (pkt_q.lsu_op)
            LD_B:    rw_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
            LD_BU:   rw_data = {24'b0, ld_shift[7:0]};
            LD_H:    rw_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
            LD_HU:   rw_data = {16'b0, ld_shift[15:0]};
            LD_W:    rw_data = ld_shift;
            default: rw_data = pkt_q.ex_result;
        endcase
    end

    assign wb_valid        = wb_valid_q;
    assign ale             = ale_q;
    assign wb_csr          = csr_q;
    assign wb_pkt.pc       = pkt_q.pc;
    assign wb_pkt.inst     = pkt_q.inst;
    assign wb_pkt.rw_en    = pkt_q.rw_en;
    assign wb_pkt.rw_addr  = pkt_q.rw_addr;
    assign wb_pkt.rw_data  = rw_data;

    // Strobe width must agree with the store size
    assert property (@(posedge clk) disable iff (!rst_n)
        data_req.en && data_req.we |->
            (ex_pkt.lsu_op == ST_B && $countones(data_req.strb) == 1) ||
            (ex_pkt.lsu_op == ST_H && data_req.strb inside {4'b0011, 4'b0110, 4'b1100}) ||
            (ex_pkt.lsu_op == ST_W && data_req.strb == 4'b1111));

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

    localparam int MEM_WORDS  = 1024;
    localparam int MEM_AWIDTH = $clog2(MEM_WORDS);

    typedef logic [31:0]           addr_t;
    typedef logic [31:0]           data_t;
    typedef logic [31:0]           inst_t;
    typedef logic [3:0]            strb_t;
    typedef logic [MEM_AWIDTH-1:0] word_idx_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [13:0]           csr_addr_t;

    // Bit 2 marks a store, bit 3 an unsigned load
    typedef enum logic [3:0] {
        LD_B     = 4'b0000,
        LD_H     = 4'b0001,
        LD_W     = 4'b0010,
        ST_B     = 4'b0100,
        ST_H     = 4'b0101,
        ST_W     = 4'b0110,
        LD_BU    = 4'b1000,
        LD_HU    = 4'b1001,
        LSU_NONE = 4'b1111
    } lsu_op_t;

    typedef struct packed {
        addr_t    pc;
        inst_t    inst;
        logic     rw_en;
        reg_idx_t rw_addr;
        lsu_op_t  lsu_op;
        addr_t    ex_result;    // ALU result or effective address
        data_t    lsu_data;     // Store data
    } ex_pkt_t;

    typedef struct packed {
        addr_t    pc;
        inst_t    inst;
        logic     rw_en;
        reg_idx_t rw_addr;
        data_t    rw_data;
    } wb_pkt_t;

    typedef struct packed {
        logic      rw_en;
        csr_addr_t rw_addr;
        data_t     rw_data;
    } csr_pkt_t;

    // Shared by both requesters and the SRAM port
    typedef struct packed {
        logic      en;
        logic      we;
        word_idx_t idx;
        data_t     wdata;
        strb_t     strb;
    } mem_req_t;

endpackage
